/* screen_pkg.sv */
`default_nettype none

package screen_pkg;

    // 10 bits covers screens up to 1023 pixels
    localparam int COORD_WIDTH = 10;
    typedef logic [COORD_WIDTH-1:0] coord_t;

    localparam int VRAM_A_WIDTH = 17;
    typedef logic [VRAM_A_WIDTH-1:0] vram_addr_t;

    // drawing order within a frame
    typedef enum logic [2:0] {
        LAYER_IDLE       = 3'd0,
        LAYER_BACKGROUND = 3'd1,
        LAYER_FAILHOLE   = 3'd2,
        LAYER_WINHOLE    = 3'd3,
        LAYER_BALL       = 3'd4,
        LAYER_OPTION     = 3'd5,
        LAYER_SELECT     = 3'd6
    } layer_t;

endpackage

`default_nettype wire

/* sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

    // slot numbers in the sprite buffer
    typedef enum logic [3:0] {
        SPR_BACKGROUND = 4'd0,
        SPR_BALL       = 4'd1,
        SPR_FAILHOLE   = 4'd2,
        SPR_WINHOLE    = 4'd3,
        SPR_SELECT     = 4'd6,
        SPR_PAUSE      = 4'd8,
        SPR_FAIL       = 4'd9,
        SPR_WIN        = 4'd10
    } sprite_t;

    localparam int SPRITEBUF_A_WIDTH = 15;
    typedef logic [SPRITEBUF_A_WIDTH-1:0] sprite_addr_t;

endpackage

`default_nettype wire

/* draw_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface draw_if;

    logic                   req;
    logic                   ack;
    screen_pkg::coord_t     pos_x;
    screen_pkg::coord_t     pos_y;
    screen_pkg::coord_t     width;
    screen_pkg::coord_t     height;
    sprite_pkg::sprite_t    sprite;

    // rectangle fields come from the placement unit, stable while req is high
    modport sequencer (
        output req, pos_x, pos_y, width, height, sprite,
        input  ack
    );

    modport walker (
        input  req, pos_x, pos_y, width, height, sprite,
        output ack
    );

endinterface

`default_nettype wire

/* layer_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer (
    input  wire                     CLK,
    input  wire                     rst,
    input  wire                     i_frame_start,
    input  wire                     i_pause,
    input  wire                     i_fail,
    input  wire                     i_win,
    input  wire                     i_last_hole,
    output screen_pkg::layer_t      o_layer,
    output logic                    o_hole_clear,
    output logic                    o_hole_step,
    output logic                    o_is_layer_drawing,
    draw_if.sequencer               draw
);

    screen_pkg::layer_t layer;
    screen_pkg::layer_t next_layer;
    logic               layer_done;

    assign layer_done = draw.req && draw.ack;

    // status bits are looked at only when the ball layer finishes
    always_comb begin
        case (layer)
            screen_pkg::LAYER_BACKGROUND: next_layer = screen_pkg::LAYER_FAILHOLE;
            screen_pkg::LAYER_FAILHOLE: begin
                if (i_last_hole) begin
                    next_layer = screen_pkg::LAYER_WINHOLE;
                end else begin
                    next_layer = screen_pkg::LAYER_FAILHOLE;
                end
            end
            screen_pkg::LAYER_WINHOLE: next_layer = screen_pkg::LAYER_BALL;
            screen_pkg::LAYER_BALL: begin
                if (i_pause || i_fail || i_win) begin
                    next_layer = screen_pkg::LAYER_OPTION;
                end else begin
                    next_layer = screen_pkg::LAYER_IDLE;
                end
            end
            screen_pkg::LAYER_OPTION: next_layer = screen_pkg::LAYER_SELECT;
            default: next_layer = screen_pkg::LAYER_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            layer    <= screen_pkg::LAYER_IDLE;
            draw.req <= 1'b0;
        end else if (layer == screen_pkg::LAYER_IDLE) begin
            if (i_frame_start) begin
                layer <= screen_pkg::LAYER_BACKGROUND;
                // ack may still be high right after the previous frame
                draw.req <= !draw.ack;
            end
        end else if (layer_done) begin
            draw.req <= 1'b0;
            layer    <= next_layer;
        end else if (!draw.req && !draw.ack) begin
            draw.req <= 1'b1;
        end
    end

    assign o_hole_clear = (layer == screen_pkg::LAYER_IDLE) && i_frame_start;

    // advance at the end of every hole except the last
    assign o_hole_step = (layer == screen_pkg::LAYER_FAILHOLE) && layer_done && !i_last_hole;

    assign o_layer            = layer;
    assign o_is_layer_drawing = (layer != screen_pkg::LAYER_IDLE);

endmodule

`default_nettype wire

/* hole_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module hole_counter #(
    parameter int FAIL_HOLES = 7
) (
    input  wire         CLK,
    input  wire         rst,
    input  wire         i_clear,
    input  wire         i_step,
    output logic [2:0]  o_index,
    output logic        o_last
);

    localparam logic [2:0] LAST_INDEX = 3'(FAIL_HOLES - 1);

    logic [2:0] index;

    // clear wins over step
    always_ff @(posedge CLK) begin
        if (rst || i_clear) begin
            index <= 3'd0;
        end else if (i_step) begin
            index <= index + 3'd1;
        end
    end

    assign o_index = index;
    assign o_last  = (index == LAST_INDEX);

endmodule

`default_nettype wire

/* layer_placement.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_placement #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180,
    parameter int SPRITE_SIZE   = 32,
    parameter int FAIL_HOLES    = 7
) (
    input  screen_pkg::layer_t                              i_layer,
    input  wire [2:0]                                       i_hole_index,
    input  screen_pkg::coord_t                              i_ball_x,
    input  screen_pkg::coord_t                              i_ball_y,
    input  screen_pkg::coord_t                              i_win_x,
    input  screen_pkg::coord_t                              i_win_y,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_x,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_y,
    input  wire                                             i_pause,
    input  wire                                             i_fail,
    input  wire                                             i_win,
    input  wire [2:0]                                       i_select_pos,
    output screen_pkg::coord_t                              o_pos_x,
    output screen_pkg::coord_t                              o_pos_y,
    output screen_pkg::coord_t                              o_width,
    output screen_pkg::coord_t                              o_height,
    output sprite_pkg::sprite_t                             o_sprite
);

    localparam screen_pkg::coord_t SPR      = screen_pkg::coord_t'(SPRITE_SIZE);
    localparam screen_pkg::coord_t OPT_X    = screen_pkg::coord_t'(4 * SPRITE_SIZE + SPRITE_SIZE / 2);
    localparam screen_pkg::coord_t OPT_Y    = screen_pkg::coord_t'(2 * SPRITE_SIZE);

    screen_pkg::coord_t     hole_x;
    screen_pkg::coord_t     hole_y;
    screen_pkg::coord_t     sel_y;
    sprite_pkg::sprite_t    option_sprite;

    assign hole_x = i_fail_x[i_hole_index*screen_pkg::COORD_WIDTH +: screen_pkg::COORD_WIDTH];
    assign hole_y = i_fail_y[i_hole_index*screen_pkg::COORD_WIDTH +: screen_pkg::COORD_WIDTH];

    // menu rows are 7 pixels apart
    assign sel_y = OPT_Y + screen_pkg::coord_t'(i_select_pos) * screen_pkg::coord_t'(7);

    assign option_sprite = i_pause ? sprite_pkg::SPR_PAUSE :
                           i_fail  ? sprite_pkg::SPR_FAIL  : sprite_pkg::SPR_WIN;

    always_comb begin
        o_pos_x  = '0;
        o_pos_y  = '0;
        o_width  = SPR;
        o_height = SPR;
        o_sprite = sprite_pkg::SPR_BACKGROUND;
        case (i_layer)
            screen_pkg::LAYER_BACKGROUND: begin
                o_width  = screen_pkg::coord_t'(SCREEN_WIDTH);
                o_height = screen_pkg::coord_t'(SCREEN_HEIGHT);
            end
            screen_pkg::LAYER_FAILHOLE: begin
                o_pos_x  = hole_x;
                o_pos_y  = hole_y;
                o_sprite = sprite_pkg::SPR_FAILHOLE;
            end
            screen_pkg::LAYER_WINHOLE: begin
                o_pos_x  = i_win_x;
                o_pos_y  = i_win_y;
                o_sprite = sprite_pkg::SPR_WINHOLE;
            end
            screen_pkg::LAYER_BALL: begin
                o_pos_x  = i_ball_x;
                o_pos_y  = i_ball_y;
                o_sprite = sprite_pkg::SPR_BALL;
            end
            screen_pkg::LAYER_OPTION: begin
                o_pos_x  = OPT_X;
                o_pos_y  = OPT_Y;
                o_sprite = option_sprite;
            end
            screen_pkg::LAYER_SELECT: begin
                o_pos_x  = OPT_X;
                o_pos_y  = sel_y;
                o_sprite = sprite_pkg::SPR_SELECT;
            end
            default: begin
                o_width  = '0;
                o_height = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* sprite_walker.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_walker #(
    parameter int SCREEN_WIDTH = 320,
    parameter int SPRITE_SIZE  = 32
) (
    input  wire                         CLK,
    input  wire                         rst,
    draw_if.walker                      draw,
    output screen_pkg::vram_addr_t      o_address_screen,
    output sprite_pkg::sprite_addr_t    o_address_sprite,
    output logic                        o_pixel_valid
);

    localparam int SPRITE_BITS = $clog2(SPRITE_SIZE);

    screen_pkg::coord_t         pix_x;
    screen_pkg::coord_t         pix_y;
    logic                       busy;
    logic                       last_col;
    logic                       last_row;
    logic [SPRITE_BITS-1:0]     tile_x;
    logic [SPRITE_BITS-1:0]     tile_y;
    screen_pkg::vram_addr_t     row;
    screen_pkg::vram_addr_t     col;

    assign last_col = (pix_x == draw.width - screen_pkg::coord_t'(1));
    assign last_row = (pix_y == draw.height - screen_pkg::coord_t'(1));

    // row-major walk, ack one cycle after the last pixel
    always_ff @(posedge CLK) begin
        if (rst) begin
            busy     <= 1'b0;
            draw.ack <= 1'b0;
            pix_x    <= '0;
            pix_y    <= '0;
        end else if (busy) begin
            if (last_col) begin
                pix_x <= '0;
                pix_y <= pix_y + screen_pkg::coord_t'(1);
                if (last_row) begin
                    busy     <= 1'b0;
                    draw.ack <= 1'b1;
                end
            end else begin
                pix_x <= pix_x + screen_pkg::coord_t'(1);
            end
        end else if (draw.ack) begin
            if (!draw.req) begin
                draw.ack <= 1'b0;
            end
        end else if (draw.req) begin
            busy  <= 1'b1;
            pix_x <= '0;
            pix_y <= '0;
        end
    end

    assign row = screen_pkg::vram_addr_t'(draw.pos_y) + screen_pkg::vram_addr_t'(pix_y);
    assign col = screen_pkg::vram_addr_t'(draw.pos_x) + screen_pkg::vram_addr_t'(pix_x);

    assign o_address_screen = row * screen_pkg::vram_addr_t'(SCREEN_WIDTH) + col;

    // low bits wrap the background tile
    assign tile_x = pix_x[SPRITE_BITS-1:0];
    assign tile_y = pix_y[SPRITE_BITS-1:0];

    assign o_address_sprite = sprite_pkg::sprite_addr_t'({draw.sprite, tile_y, tile_x});

    assign o_pixel_valid = busy;

endmodule

`default_nettype wire

/* layer_compositor.sv */
`timescale 1ns/1ns
`default_nettype none

module layer_compositor #(
    parameter int SCREEN_WIDTH  = 320,
    parameter int SCREEN_HEIGHT = 180,
    parameter int SPRITE_SIZE   = 32,
    parameter int FAIL_HOLES    = 7
) (
    input  wire                                             CLK,
    input  wire                                             rst,
    input  wire                                             i_frame_start,
    input  screen_pkg::coord_t                              i_ball_x,
    input  screen_pkg::coord_t                              i_ball_y,
    input  screen_pkg::coord_t                              i_win_x,
    input  screen_pkg::coord_t                              i_win_y,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_x,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_y,
    input  wire                                             i_pause,
    input  wire                                             i_fail,
    input  wire                                             i_win,
    input  wire [2:0]                                       i_select_pos,
    output screen_pkg::vram_addr_t                          o_address_screen,
    output sprite_pkg::sprite_addr_t                        o_address_sprite,
    output logic                                            o_pixel_valid,
    output logic                                            o_is_layer_drawing
);

    screen_pkg::layer_t layer;
    logic               hole_clear;
    logic               hole_step;
    logic [2:0]         hole_index;
    logic               last_hole;

    draw_if draw_bus ();

    layer_sequencer u_sequencer (
        .CLK                (CLK),
        .rst                (rst),
        .i_frame_start      (i_frame_start),
        .i_pause            (i_pause),
        .i_fail             (i_fail),
        .i_win              (i_win),
        .i_last_hole        (last_hole),
        .o_layer            (layer),
        .o_hole_clear       (hole_clear),
        .o_hole_step        (hole_step),
        .o_is_layer_drawing (o_is_layer_drawing),
        .draw               (draw_bus.sequencer)
    );

    hole_counter #(
        .FAIL_HOLES (FAIL_HOLES)
    ) u_hole_counter (
        .CLK     (CLK),
        .rst     (rst),
        .i_clear (hole_clear),
        .i_step  (hole_step),
        .o_index (hole_index),
        .o_last  (last_hole)
    );

    // placement fills the rectangle fields on the sequencer side of the bus
    layer_placement #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .SPRITE_SIZE   (SPRITE_SIZE),
        .FAIL_HOLES    (FAIL_HOLES)
    ) u_placement (
        .i_layer      (layer),
        .i_hole_index (hole_index),
        .i_ball_x     (i_ball_x),
        .i_ball_y     (i_ball_y),
        .i_win_x      (i_win_x),
        .i_win_y      (i_win_y),
        .i_fail_x     (i_fail_x),
        .i_fail_y     (i_fail_y),
        .i_pause      (i_pause),
        .i_fail       (i_fail),
        .i_win        (i_win),
        .i_select_pos (i_select_pos),
        .o_pos_x      (draw_bus.pos_x),
        .o_pos_y      (draw_bus.pos_y),
        .o_width      (draw_bus.width),
        .o_height     (draw_bus.height),
        .o_sprite     (draw_bus.sprite)
    );

    sprite_walker #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SPRITE_SIZE  (SPRITE_SIZE)
    ) u_walker (
        .CLK              (CLK),
        .rst              (rst),
        .draw             (draw_bus.walker),
        .o_address_screen (o_address_screen),
        .o_address_sprite (o_address_sprite),
        .o_pixel_valid    (o_pixel_valid)
    );

endmodule

`default_nettype wire

/* compositor_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module compositor_assert (
    input wire CLK,
    input wire rst,
    input wire i_req,
    input wire i_ack,
    input wire i_pixel_valid
);

    int failures = 0;

    // req holds until the walker answers
    req_held: assert property (@(posedge CLK) disable iff (rst) (i_req && !i_ack) |=> i_req)
        else begin
            $error("req dropped before ack rose");
            failures++;
        end

    ack_needs_req: assert property (@(posedge CLK) disable iff (rst) $rose(i_ack) |-> i_req)
        else begin
            $error("ack rose while req was low");
            failures++;
        end

    no_pixel_during_ack: assert property (@(posedge CLK) disable iff (rst)
                                          i_pixel_valid |-> !i_ack)
        else begin
            $error("pixel valid while ack is high");
            failures++;
        end

endmodule

bind sprite_walker compositor_assert u_handshake_assert (
    .CLK           (CLK),
    .rst           (rst),
    .i_req         (draw.req),
    .i_ack         (draw.ack),
    .i_pixel_valid (o_pixel_valid)
);

`default_nettype wire

/* compositor_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module compositor_checker #(
    parameter int SCREEN_WIDTH  = 96,
    parameter int SCREEN_HEIGHT = 80,
    parameter int SPRITE_SIZE   = 8,
    parameter int FAIL_HOLES    = 4
) (
    input  wire                                             CLK,
    input  wire                                             rst,
    input  wire                                             i_frame_start,
    input  screen_pkg::coord_t                              i_ball_x,
    input  screen_pkg::coord_t                              i_ball_y,
    input  screen_pkg::coord_t                              i_win_x,
    input  screen_pkg::coord_t                              i_win_y,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_x,
    input  wire [FAIL_HOLES*screen_pkg::COORD_WIDTH-1:0]    i_fail_y,
    input  wire                                             i_pause,
    input  wire                                             i_fail,
    input  wire                                             i_win,
    input  wire [2:0]                                       i_select_pos,
    input  screen_pkg::vram_addr_t                          i_address_screen,
    input  sprite_pkg::sprite_addr_t                        i_address_sprite,
    input  wire                                             i_pixel_valid,
    input  wire                                             i_is_layer_drawing,
    output int                                              o_errors,
    output int                                              o_pixels,
    output int                                              o_frames
);

    localparam int CW = screen_pkg::COORD_WIDTH;

    int                         exp_screen[$];
    int                         exp_sprite[$];
    bit                         in_frame;
    screen_pkg::vram_addr_t     want_screen;
    sprite_pkg::sprite_addr_t   want_sprite;

    // row-major pixels of one rectangle, sprite index wraps every SPRITE_SIZE
    task automatic add_rect(input int px, input int py, input int w, input int h, input int spr);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                exp_screen.push_back((py + y) * SCREEN_WIDTH + px + x);
                exp_sprite.push_back(spr * SPRITE_SIZE * SPRITE_SIZE
                                     + (y % SPRITE_SIZE) * SPRITE_SIZE + (x % SPRITE_SIZE));
            end
        end
    endtask

    task automatic build_frame();
        int option_x;
        int option_y;
        int option_sprite;
        option_x = (9 * SPRITE_SIZE) / 2;
        option_y = 2 * SPRITE_SIZE;
        add_rect(0, 0, SCREEN_WIDTH, SCREEN_HEIGHT, int'(sprite_pkg::SPR_BACKGROUND));
        for (int h = 0; h < FAIL_HOLES; h++) begin
            add_rect(int'(i_fail_x[h*CW +: CW]), int'(i_fail_y[h*CW +: CW]),
                     SPRITE_SIZE, SPRITE_SIZE, int'(sprite_pkg::SPR_FAILHOLE));
        end
        add_rect(int'(i_win_x), int'(i_win_y), SPRITE_SIZE, SPRITE_SIZE,
                 int'(sprite_pkg::SPR_WINHOLE));
        add_rect(int'(i_ball_x), int'(i_ball_y), SPRITE_SIZE, SPRITE_SIZE,
                 int'(sprite_pkg::SPR_BALL));
        if (i_pause || i_fail || i_win) begin
            if (i_pause) begin
                option_sprite = int'(sprite_pkg::SPR_PAUSE);
            end else if (i_fail) begin
                option_sprite = int'(sprite_pkg::SPR_FAIL);
            end else begin
                option_sprite = int'(sprite_pkg::SPR_WIN);
            end
            add_rect(option_x, option_y, SPRITE_SIZE, SPRITE_SIZE, option_sprite);
            add_rect(option_x, option_y + 7 * int'(i_select_pos), SPRITE_SIZE, SPRITE_SIZE,
                     int'(sprite_pkg::SPR_SELECT));
        end
    endtask

    // sampled mid-cycle, away from the driving edge
    always @(negedge CLK) begin
        if (rst) begin
            exp_screen.delete();
            exp_sprite.delete();
            in_frame = 1'b0;
            o_errors = 0;
            o_pixels = 0;
            o_frames = 0;
        end else begin
            if (i_pixel_valid) begin
                if (exp_screen.size() == 0) begin
                    $display("pixel valid at %0t ns with no pixel expected", $time);
                    o_errors++;
                end else begin
                    want_screen = screen_pkg::vram_addr_t'(exp_screen.pop_front());
                    want_sprite = sprite_pkg::sprite_addr_t'(exp_sprite.pop_front());
                    o_pixels++;
                    if (i_address_screen !== want_screen) begin
                        $display("error o_address_screen exp %h got %h",
                                 want_screen, i_address_screen);
                        o_errors++;
                    end
                    if (i_address_sprite !== want_sprite) begin
                        $display("error o_address_sprite exp %h got %h",
                                 want_sprite, i_address_sprite);
                        o_errors++;
                    end
                end
            end
            if (in_frame && !i_is_layer_drawing) begin
                if (exp_screen.size() != 0) begin
                    $display("frame ended with %0d pixels not drawn", exp_screen.size());
                    o_errors++;
                end
                exp_screen.delete();
                exp_sprite.delete();
                in_frame = 1'b0;
                o_frames++;
            end else if (!in_frame && i_is_layer_drawing) begin
                $display("o_is_layer_drawing high at %0t ns without a frame start", $time);
                o_errors++;
            end
            // a pulse during a frame is ignored by the DUT and here too
            if (!in_frame && !i_is_layer_drawing && i_frame_start) begin
                build_frame();
                in_frame = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_layer_compositor.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_layer_compositor;

    localparam int SCREEN_WIDTH  = 96;
    localparam int SCREEN_HEIGHT = 80;
    localparam int SPRITE_SIZE   = 8;
    localparam int FAIL_HOLES    = 4;
    localparam int CW            = screen_pkg::COORD_WIDTH;
    localparam int NUM_FRAMES    = 17;
    localparam int FRAME_CYCLES  = SCREEN_WIDTH * SCREEN_HEIGHT
                                   + 9 * SPRITE_SIZE * SPRITE_SIZE + 200;
    localparam int TIMEOUT_NS    = (NUM_FRAMES + 2) * FRAME_CYCLES * 20;

    logic                           CLK;
    logic                           rst;
    logic                           frame_start;
    screen_pkg::coord_t             ball_x;
    screen_pkg::coord_t             ball_y;
    screen_pkg::coord_t             win_x;
    screen_pkg::coord_t             win_y;
    logic [FAIL_HOLES*CW-1:0]       fail_x;
    logic [FAIL_HOLES*CW-1:0]       fail_y;
    logic                           pause;
    logic                           fail;
    logic                           win;
    logic [2:0]                     select_pos;
    screen_pkg::vram_addr_t         address_screen;
    sprite_pkg::sprite_addr_t       address_sprite;
    logic                           pixel_valid;
    logic                           is_layer_drawing;
    int                             errors;
    int                             pixels;
    int                             frames;
    int                             tb_errors;
    int                             tests;
    int                             start_errors;
    int                             start_pixels;
    int                             start_frames;
    int                             status;
    int                             total;
    logic [31:0]                    lfsr;

    layer_compositor #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .SPRITE_SIZE   (SPRITE_SIZE),
        .FAIL_HOLES    (FAIL_HOLES)
    ) DUT (
        .CLK                (CLK),
        .rst                (rst),
        .i_frame_start      (frame_start),
        .i_ball_x           (ball_x),
        .i_ball_y           (ball_y),
        .i_win_x            (win_x),
        .i_win_y            (win_y),
        .i_fail_x           (fail_x),
        .i_fail_y           (fail_y),
        .i_pause            (pause),
        .i_fail             (fail),
        .i_win              (win),
        .i_select_pos       (select_pos),
        .o_address_screen   (address_screen),
        .o_address_sprite   (address_sprite),
        .o_pixel_valid      (pixel_valid),
        .o_is_layer_drawing (is_layer_drawing)
    );

    compositor_checker #(
        .SCREEN_WIDTH  (SCREEN_WIDTH),
        .SCREEN_HEIGHT (SCREEN_HEIGHT),
        .SPRITE_SIZE   (SPRITE_SIZE),
        .FAIL_HOLES    (FAIL_HOLES)
    ) u_checker (
        .CLK                (CLK),
        .rst                (rst),
        .i_frame_start      (frame_start),
        .i_ball_x           (ball_x),
        .i_ball_y           (ball_y),
        .i_win_x            (win_x),
        .i_win_y            (win_y),
        .i_fail_x           (fail_x),
        .i_fail_y           (fail_y),
        .i_pause            (pause),
        .i_fail             (fail),
        .i_win              (win),
        .i_select_pos       (select_pos),
        .i_address_screen   (address_screen),
        .i_address_sprite   (address_sprite),
        .i_pixel_valid      (pixel_valid),
        .i_is_layer_drawing (is_layer_drawing),
        .o_errors           (errors),
        .o_pixels           (pixels),
        .o_frames           (frames)
    );

    always #10 CLK = ~CLK;

    // x^32 + x^22 + x^2 + x + 1 in right-shift form
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        if (state[0]) begin
            next = (state >> 1) ^ 32'h8020_0003;
        end else begin
            next = state >> 1;
        end
        return next;
    endfunction

    function automatic int count_errors();
        return errors + tb_errors + DUT.u_walker.u_handshake_assert.failures;
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic random_coord(input int limit, output screen_pkg::coord_t coord);
        int value;
        random_bits(10, value);
        coord = screen_pkg::coord_t'(value % (limit + 1));
    endtask

    // every sprite stays fully on screen
    task automatic randomize_scene();
        screen_pkg::coord_t c;
        int value;
        random_coord(SCREEN_WIDTH - SPRITE_SIZE, ball_x);
        random_coord(SCREEN_HEIGHT - SPRITE_SIZE, ball_y);
        random_coord(SCREEN_WIDTH - SPRITE_SIZE, win_x);
        random_coord(SCREEN_HEIGHT - SPRITE_SIZE, win_y);
        for (int h = 0; h < FAIL_HOLES; h++) begin
            random_coord(SCREEN_WIDTH - SPRITE_SIZE, c);
            fail_x[h*CW +: CW] = c;
            random_coord(SCREEN_HEIGHT - SPRITE_SIZE, c);
            fail_y[h*CW +: CW] = c;
        end
        random_bits(3, value);
        select_pos = 3'(value);
    endtask

    task automatic set_status(input int bits);
        pause = bits[0];
        fail  = bits[1];
        win   = bits[2];
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic run_frame(input bit extra_pulse);
        frame_start = 1'b1;
        @(posedge CLK);
        #2;
        frame_start = 1'b0;
        wait (is_layer_drawing);
        if (extra_pulse) begin
            repeat (40) @(posedge CLK);
            #2;
            frame_start = 1'b1;
            @(posedge CLK);
            #2;
            frame_start = 1'b0;
        end
        wait (!is_layer_drawing);
        @(posedge CLK);
        #2;
    endtask

    task automatic start_test();
        start_errors = count_errors();
        start_pixels = pixels;
        start_frames = frames;
    endtask

    task automatic end_test(input string name, input int want_frames);
        int new_frames;
        int new_errors;
        new_frames = frames - start_frames;
        if (new_frames != want_frames) begin
            $display("%0s: %0d frames drawn where %0d were started", name, new_frames,
                     want_frames);
            tb_errors++;
        end
        new_errors = count_errors() - start_errors;
        tests++;
        $display("test %0s: %0d frames, %0d pixels, %0d errors", name, new_frames,
                 pixels - start_pixels, new_errors);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: frames still not finished after %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        CLK         = 1'b0;
        rst         = 1'b1;
        frame_start = 1'b0;
        ball_x      = '0;
        ball_y      = '0;
        win_x       = '0;
        win_y       = '0;
        fail_x      = '0;
        fail_y      = '0;
        pause       = 1'b0;
        fail        = 1'b0;
        win         = 1'b0;
        select_pos  = 3'd0;
        tb_errors   = 0;
        tests       = 0;
        lfsr        = 32'd85631;
        repeat (8) @(posedge CLK);
        #2;
        rst = 1'b0;

        start_test();
        repeat (30) @(posedge CLK);
        #2;
        end_test("idle after reset", 0);

        start_test();
        randomize_scene();
        set_status(0);
        run_frame(1'b0);
        end_test("plain frame", 1);

        // pause, fail and win alone and then mixed
        start_test();
        for (int k = 0; k < 7; k++) begin
            randomize_scene();
            if (k < 3) begin
                status = 1 << k;
            end else begin
                random_bits(3, status);
                if (status == 0) begin
                    status = 7;
                end
            end
            set_status(status);
            run_frame(1'b0);
        end
        end_test("option panel frames", 7);

        start_test();
        randomize_scene();
        set_status(0);
        run_frame(1'b1);
        end_test("frame start during frame", 1);

        start_test();
        for (int k = 0; k < 8; k++) begin
            randomize_scene();
            random_bits(3, status);
            set_status(status);
            run_frame(1'b0);
        end
        end_test("back-to-back frames", 8);

        total = count_errors();
        $display("%0d tests, %0d frames, %0d pixels, %0d errors", tests, frames, pixels, total);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
screen_pkg.sv
sprite_pkg.sv
draw_if.sv
layer_sequencer.sv
hole_counter.sv
layer_placement.sv
sprite_walker.sv
layer_compositor.sv
compositor_assert.sv
compositor_checker.sv
tb_layer_compositor.sv

/* Makefile */
SRCS := $(shell cat vlog.f)

obj_dir/Vtb_layer_compositor: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_layer_compositor -f vlog.f

run: obj_dir/Vtb_layer_compositor
	obj_dir/Vtb_layer_compositor > sim.log 2>&1; echo "exit code $$?" >> sim.log
	cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "exit code 0" sim.log || (echo "simulation aborted"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
